// File: rtl/state_id_consts.svh
`ifndef STATE_ID_CONSTS_SVH
`define STATE_ID_CONSTS_SVH

// Flow key width, sets the key table depth
`define STATE_ID_KEY_WID 6

// State ID width, sets the number of IDs and the reverse map depth
`define STATE_ID_ID_WID 4

`endif

// File: rtl/state_id_pkg.sv
package state_id_pkg;

    `include "state_id_consts.svh"

    // ----------------------------------------
    // Basic types
    // ----------------------------------------
    typedef logic [`STATE_ID_KEY_WID-1:0] key_t;
    typedef logic [`STATE_ID_ID_WID-1:0]  id_t;

    // One word of the key-indexed table
    typedef struct packed {
        logic valid;
        id_t  id;
    } key_entry_t;

    // ----------------------------------------
    // Delete-by-ID FSM
    // ----------------------------------------
    typedef enum logic [3:0] {
        DELETE_RESET          = 4'd0,
        DELETE_IDLE           = 4'd1,
        DELETE_REVMAP_REQ     = 4'd2,
        DELETE_REVMAP_PENDING = 4'd3,
        DELETE_REQ            = 4'd4,
        DELETE_PENDING        = 4'd5,
        DELETE_DEALLOC_ID     = 4'd6,
        DELETE_DONE           = 4'd7,
        DELETE_ERROR          = 4'd8
    } delete_state_t;

endpackage : state_id_pkg

// File: rtl/ram_sdp.sv
`timescale 1ns/100ps

module ram_sdp #(
    parameter int  ADDR_WID = 4,
    parameter type DATA_T   = logic [7:0]
)(
    input  logic                clk,
    input  logic                srst,
    output logic                rdy,
    input  logic                wr_req,
    input  logic [ADDR_WID-1:0] wr_addr,
    input  DATA_T               wr_data,
    input  logic                rd_req,
    input  logic [ADDR_WID-1:0] rd_addr,
    output logic                rd_ack,
    output DATA_T               rd_data
);

    localparam int DEPTH = 2**ADDR_WID;

    DATA_T               mem [DEPTH];
    logic [ADDR_WID-1:0] init_addr;

    // ----------------------------------------
    // Clearing sweep after reset
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            rdy       <= 1'b0;
            init_addr <= '0;
        end else if (!rdy) begin
            init_addr <= init_addr + 1'b1;
            // Last address written this cycle
            if (&init_addr) rdy <= 1'b1;
        end
    end

    // Write port, the sweep has priority until done
    always_ff @(posedge clk) begin
        if (!rdy) mem[init_addr] <= '0;
        else if (wr_req) mem[wr_addr] <= wr_data;
    end

    // ----------------------------------------
    // Registered read port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) rd_ack <= 1'b0;
        else      rd_ack <= rd_req && rdy;
    end

    always_ff @(posedge clk) begin
        if (rd_req && rdy) rd_data <= mem[rd_addr];
    end

endmodule : ram_sdp

// File: rtl/id_alloc_bv.sv
`timescale 1ns/100ps

module id_alloc_bv (
    input  logic              clk,
    input  logic              srst,
    output logic              init_done,
    // Allocation
    input  logic              alloc_req,
    output logic              alloc_rdy,
    output state_id_pkg::id_t alloc_id,
    // Free
    input  logic              dealloc_req,
    output logic              dealloc_rdy,
    input  state_id_pkg::id_t dealloc_id
);

    localparam int ID_WID  = $bits(state_id_pkg::id_t);
    localparam int NUM_IDS = 2**ID_WID;

    // One bit per ID, set while the ID is handed out
    logic [NUM_IDS-1:0] used;
    logic [NUM_IDS-1:0] used_nxt;

    logic alloc_acc;
    logic dealloc_acc;

    // ----------------------------------------
    // Priority encoder
    // ----------------------------------------
    // Walks down so that the lowest clear bit wins
    function automatic state_id_pkg::id_t lowest_free(input logic [NUM_IDS-1:0] used_vec);
        state_id_pkg::id_t id;
        id = '0;
        for (int i = NUM_IDS-1; i >= 0; i--) begin
            if (!used_vec[i]) id = state_id_pkg::id_t'(i);
        end
        return id;
    endfunction

    assign alloc_id = lowest_free(used);

    // ----------------------------------------
    // Ready and accept
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) init_done <= 1'b0;
        else      init_done <= 1'b1;
    end

    // Full when every bit is set
    assign alloc_rdy   = init_done && !(&used);
    assign dealloc_rdy = init_done;

    assign alloc_acc   = alloc_req && alloc_rdy;
    assign dealloc_acc = dealloc_req && dealloc_rdy;

    // ----------------------------------------
    // Used-bit update
    // ----------------------------------------
    // Allocate and free may land in the same cycle
    always_comb begin
        used_nxt = used;
        if (alloc_acc)   used_nxt[alloc_id]   = 1'b1;
        if (dealloc_acc) used_nxt[dealloc_id] = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (srst) used <= '0;
        else      used <= used_nxt;
    end

endmodule : id_alloc_bv

// File: rtl/key_id_table.sv
`timescale 1ns/100ps

`include "state_id_consts.svh"

module key_id_table (
    input  logic               clk,
    input  logic               srst,
    output logic               tbl_rdy,
    // Insert, written without back-pressure
    input  logic               tbl_insert_req,
    input  state_id_pkg::key_t tbl_insert_key,
    input  state_id_pkg::id_t  tbl_insert_id,
    // Delete by key
    input  logic               del_req,
    output logic               del_rdy,
    input  state_id_pkg::key_t del_key,
    output logic               del_ack,
    output logic               del_error
);

    typedef enum logic [1:0] {
        TBL_IDLE,
        TBL_READ,
        TBL_WRITEBACK
    } tbl_state_t;

    tbl_state_t tbl_state;

    logic ram_rdy;
    logic wr_req;
    logic rd_req;
    logic rd_ack;

    state_id_pkg::key_t       wr_addr;
    state_id_pkg::key_entry_t wr_data;
    state_id_pkg::key_entry_t rd_data;

    // Delete context
    state_id_pkg::key_t del_key_r;
    logic               entry_valid_r;

    // ----------------------------------------
    // Table storage
    // ----------------------------------------
    ram_sdp #(
        .ADDR_WID ( `STATE_ID_KEY_WID ),
        .DATA_T   ( state_id_pkg::key_entry_t )
    ) i_ram_sdp__table (
        .clk      ( clk ),
        .srst     ( srst ),
        .rdy      ( ram_rdy ),
        .wr_req   ( wr_req ),
        .wr_addr  ( wr_addr ),
        .wr_data  ( wr_data ),
        .rd_req   ( rd_req ),
        .rd_addr  ( del_key ),
        .rd_ack   ( rd_ack ),
        .rd_data  ( rd_data )
    );

    // Inserts are held off while the write port is taken by a writeback
    assign tbl_rdy = ram_rdy && (tbl_state != TBL_WRITEBACK);
    assign del_rdy = ram_rdy && (tbl_state == TBL_IDLE);

    // Lookup goes out in the accept cycle
    assign rd_req = del_req && del_rdy;

    // ----------------------------------------
    // Write port mux
    // ----------------------------------------
    always_comb begin
        if (tbl_state == TBL_WRITEBACK) begin
            // Nothing to clear when the entry was already invalid
            wr_req  = entry_valid_r;
            wr_addr = del_key_r;
            wr_data = '{valid: 1'b0, id: '0};
        end else begin
            wr_req  = tbl_insert_req;
            wr_addr = tbl_insert_key;
            wr_data = '{valid: 1'b1, id: tbl_insert_id};
        end
    end

    // ----------------------------------------
    // Delete FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            tbl_state <= TBL_IDLE;
        end else begin
            case (tbl_state)
                TBL_IDLE      : if (rd_req) tbl_state <= TBL_READ;
                TBL_READ      : if (rd_ack) tbl_state <= TBL_WRITEBACK;
                TBL_WRITEBACK : tbl_state <= TBL_IDLE;
                default       : tbl_state <= TBL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req) del_key_r <= del_key;
        if (rd_ack) entry_valid_r <= rd_data.valid;
    end

    assign del_ack   = (tbl_state == TBL_WRITEBACK);
    assign del_error = (tbl_state == TBL_WRITEBACK) && !entry_valid_r;

endmodule : key_id_table

// File: rtl/state_id_manager.sv
`timescale 1ns/100ps

`include "state_id_consts.svh"

module state_id_manager (
    input  logic               clk,
    input  logic               srst,
    output logic               init_done,
    // Insert from the application
    output logic               insert_rdy,
    input  logic               insert_req,
    input  state_id_pkg::key_t insert_key,
    output state_id_pkg::id_t  insert_id,
    // Delete by ID from the application
    output logic               delete_rdy,
    input  logic               delete_req,
    input  state_id_pkg::id_t  delete_id,
    output logic               delete_ack,
    output logic               delete_error,
    output state_id_pkg::key_t delete_key,
    // Key table, insert side
    input  logic               tbl_rdy,
    output logic               tbl_insert_req,
    output state_id_pkg::key_t tbl_insert_key,
    output state_id_pkg::id_t  tbl_insert_id,
    // Key table, delete side
    output logic               del_req,
    input  logic               del_rdy,
    output state_id_pkg::key_t del_key,
    input  logic               del_ack,
    input  logic               del_error,
    // Status
    output logic [7:0]         delete_state_mon
);

    logic alloc_init_done;
    logic alloc_req;
    logic alloc_rdy;
    logic dealloc_req;
    logic dealloc_rdy;
    logic insert_acc;

    state_id_pkg::id_t alloc_id;

    logic               revmap_rdy;
    logic               revmap_rd_req;
    logic               revmap_rd_ack;
    state_id_pkg::key_t revmap_rd_data;

    // Delete context
    state_id_pkg::id_t  delete_id_r;
    state_id_pkg::key_t delete_key_r;

    state_id_pkg::delete_state_t delete_state;
    state_id_pkg::delete_state_t nxt_delete_state;

    // ----------------------------------------
    // Init status
    // ----------------------------------------
    // Sticky, the table drops tbl_rdy during each writeback
    always_ff @(posedge clk) begin
        if (srst) init_done <= 1'b0;
        else if (alloc_init_done && revmap_rdy && tbl_rdy) init_done <= 1'b1;
    end

    // ----------------------------------------
    // ID allocator
    // ----------------------------------------
    id_alloc_bv i_id_alloc_bv (
        .clk         ( clk ),
        .srst        ( srst ),
        .init_done   ( alloc_init_done ),
        .alloc_req   ( alloc_req ),
        .alloc_rdy   ( alloc_rdy ),
        .alloc_id    ( alloc_id ),
        .dealloc_req ( dealloc_req ),
        .dealloc_rdy ( dealloc_rdy ),
        .dealloc_id  ( delete_id_r )
    );

    // Insert path
    assign insert_rdy = init_done && alloc_rdy && revmap_rdy && tbl_rdy;
    assign insert_acc = insert_req && insert_rdy;
    assign insert_id  = alloc_id;
    assign alloc_req  = insert_acc;

    assign tbl_insert_req = insert_acc;
    assign tbl_insert_key = insert_key;
    assign tbl_insert_id  = alloc_id;

    // ----------------------------------------
    // Reverse map, ID to key
    // ----------------------------------------
    ram_sdp #(
        .ADDR_WID ( `STATE_ID_ID_WID ),
        .DATA_T   ( state_id_pkg::key_t )
    ) i_ram_sdp__revmap (
        .clk      ( clk ),
        .srst     ( srst ),
        .rdy      ( revmap_rdy ),
        .wr_req   ( insert_acc ),
        .wr_addr  ( alloc_id ),
        .wr_data  ( insert_key ),
        .rd_req   ( revmap_rd_req ),
        .rd_addr  ( delete_id_r ),
        .rd_ack   ( revmap_rd_ack ),
        .rd_data  ( revmap_rd_data )
    );

    always_ff @(posedge clk) begin
        if (delete_req && delete_rdy) delete_id_r <= delete_id;
        if (revmap_rd_ack) delete_key_r <= revmap_rd_data;
    end

    assign del_key    = delete_key_r;
    assign delete_key = delete_key_r;

    // ----------------------------------------
    // Delete FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) delete_state <= state_id_pkg::DELETE_RESET;
        else      delete_state <= nxt_delete_state;
    end

    always_comb begin
        nxt_delete_state = delete_state;
        delete_rdy       = 1'b0;
        revmap_rd_req    = 1'b0;
        del_req          = 1'b0;
        dealloc_req      = 1'b0;
        delete_ack       = 1'b0;
        delete_error     = 1'b0;
        case (delete_state)
            state_id_pkg::DELETE_RESET : begin
                if (init_done) nxt_delete_state = state_id_pkg::DELETE_IDLE;
            end
            state_id_pkg::DELETE_IDLE : begin
                delete_rdy = 1'b1;
                if (delete_req) nxt_delete_state = state_id_pkg::DELETE_REVMAP_REQ;
            end
            state_id_pkg::DELETE_REVMAP_REQ : begin
                revmap_rd_req = 1'b1;
                if (revmap_rdy) nxt_delete_state = state_id_pkg::DELETE_REVMAP_PENDING;
            end
            state_id_pkg::DELETE_REVMAP_PENDING : begin
                if (revmap_rd_ack) nxt_delete_state = state_id_pkg::DELETE_REQ;
            end
            state_id_pkg::DELETE_REQ : begin
                del_req = 1'b1;
                if (del_rdy) nxt_delete_state = state_id_pkg::DELETE_PENDING;
            end
            state_id_pkg::DELETE_PENDING : begin
                // A missing entry keeps the ID allocated
                if (del_ack) begin
                    if (del_error) nxt_delete_state = state_id_pkg::DELETE_ERROR;
                    else           nxt_delete_state = state_id_pkg::DELETE_DEALLOC_ID;
                end
            end
            state_id_pkg::DELETE_DEALLOC_ID : begin
                dealloc_req = 1'b1;
                if (dealloc_rdy) nxt_delete_state = state_id_pkg::DELETE_DONE;
            end
            state_id_pkg::DELETE_DONE : begin
                delete_ack       = 1'b1;
                nxt_delete_state = state_id_pkg::DELETE_IDLE;
            end
            state_id_pkg::DELETE_ERROR : begin
                delete_ack       = 1'b1;
                delete_error     = 1'b1;
                nxt_delete_state = state_id_pkg::DELETE_IDLE;
            end
            default : begin
                nxt_delete_state = state_id_pkg::DELETE_IDLE;
            end
        endcase
    end

    assign delete_state_mon = {4'h0, delete_state};

endmodule : state_id_manager

// File: rtl/state_id_tracker.sv
`timescale 1ns/100ps

module state_id_tracker (
    input  logic               clk,
    input  logic               srst,
    output logic               init_done,
    // Insert
    output logic               insert_rdy,
    input  logic               insert_req,
    input  state_id_pkg::key_t insert_key,
    output state_id_pkg::id_t  insert_id,
    // Delete by ID
    output logic               delete_rdy,
    input  logic               delete_req,
    input  state_id_pkg::id_t  delete_id,
    output logic               delete_ack,
    output logic               delete_error,
    output state_id_pkg::key_t delete_key,
    // Status
    output logic [7:0]         delete_state_mon
);

    // Manager to key table
    logic               tbl_rdy;
    logic               tbl_insert_req;
    state_id_pkg::key_t tbl_insert_key;
    state_id_pkg::id_t  tbl_insert_id;

    logic               del_req;
    logic               del_rdy;
    state_id_pkg::key_t del_key;
    logic               del_ack;
    logic               del_error;

    // ----------------------------------------
    // Insert path, reverse map, delete FSM
    // ----------------------------------------
    state_id_manager i_state_id_manager (
        .clk              ( clk ),
        .srst             ( srst ),
        .init_done        ( init_done ),
        .insert_rdy       ( insert_rdy ),
        .insert_req       ( insert_req ),
        .insert_key       ( insert_key ),
        .insert_id        ( insert_id ),
        .delete_rdy       ( delete_rdy ),
        .delete_req       ( delete_req ),
        .delete_id        ( delete_id ),
        .delete_ack       ( delete_ack ),
        .delete_error     ( delete_error ),
        .delete_key       ( delete_key ),
        .tbl_rdy          ( tbl_rdy ),
        .tbl_insert_req   ( tbl_insert_req ),
        .tbl_insert_key   ( tbl_insert_key ),
        .tbl_insert_id    ( tbl_insert_id ),
        .del_req          ( del_req ),
        .del_rdy          ( del_rdy ),
        .del_key          ( del_key ),
        .del_ack          ( del_ack ),
        .del_error        ( del_error ),
        .delete_state_mon ( delete_state_mon )
    );

    // ----------------------------------------
    // Forward map, key to ID
    // ----------------------------------------
    key_id_table i_key_id_table (
        .clk            ( clk ),
        .srst           ( srst ),
        .tbl_rdy        ( tbl_rdy ),
        .tbl_insert_req ( tbl_insert_req ),
        .tbl_insert_key ( tbl_insert_key ),
        .tbl_insert_id  ( tbl_insert_id ),
        .del_req        ( del_req ),
        .del_rdy        ( del_rdy ),
        .del_key        ( del_key ),
        .del_ack        ( del_ack ),
        .del_error      ( del_error )
    );

endmodule : state_id_tracker

// File: tb/state_id_tracker_checker.sv
`timescale 1ns/100ps

module state_id_tracker_checker (
    input  logic               clk,
    input  logic               srst,
    // DUT ports under watch
    input  logic               insert_req,
    input  logic               insert_rdy,
    input  state_id_pkg::id_t  insert_id,
    input  logic               delete_rdy,
    input  logic               delete_ack,
    input  logic               delete_error,
    input  state_id_pkg::key_t delete_key,
    input  logic [7:0]         delete_state_mon,
    // Expected values from the reference model
    input  state_id_pkg::id_t  exp_insert_id,
    input  state_id_pkg::key_t exp_delete_key,
    input  logic               exp_delete_error,
    // Running totals
    output int                 check_count,
    output int                 error_count
);

    logic       ack_seen;
    logic [7:0] exp_state_mon;

    initial begin
        check_count = 0;
        error_count = 0;
        ack_seen    = 1'b0;
    end

    // Sampled mid-cycle, where inputs and outputs are settled
    always @(negedge clk) begin
        if (srst) begin
            ack_seen = 1'b0;
        end else begin
            // Insert ID is valid in the accept cycle
            if (insert_req && insert_rdy) begin
                check_count++;
                if (insert_id !== exp_insert_id) begin
                    error_count++;
                    $display("ERROR at %0t: insert_id %0d, expected %0d",
                             $time, insert_id, exp_insert_id);
                end
            end
            if (delete_ack) begin
                check_count++;
                if (ack_seen) begin
                    error_count++;
                    $display("delete_ack stayed high for more than one cycle at %0t", $time);
                end
                if (delete_key !== exp_delete_key || delete_error !== exp_delete_error) begin
                    error_count++;
                    $display("ERROR at %0t: delete key %0d error %0b, expected key %0d error %0b",
                             $time, delete_key, delete_error, exp_delete_key,
                             exp_delete_error);
                end
                // Ack is given from the done or the error state, never from idle
                exp_state_mon = exp_delete_error ? 8'(state_id_pkg::DELETE_ERROR)
                                                 : 8'(state_id_pkg::DELETE_DONE);
                if (delete_state_mon !== exp_state_mon) begin
                    error_count++;
                    $display("ERROR at %0t: delete_state_mon %0h with delete_ack, expected %0h",
                             $time, delete_state_mon, exp_state_mon);
                end
                if (delete_rdy !== 1'b0) begin
                    error_count++;
                    $display("ERROR at %0t: delete_rdy high with delete_ack", $time);
                end
            end
            ack_seen = delete_ack;
        end
    end

endmodule : state_id_tracker_checker

// File: tb/state_id_tracker_tb.sv
`timescale 1ns/100ps

`include "state_id_consts.svh"

module state_id_tracker_tb;

    localparam int NUM_IDS        = 1 << `STATE_ID_ID_WID;
    localparam int NUM_KEYS       = 1 << `STATE_ID_KEY_WID;
    localparam int NUM_RANDOM_OPS = 200;
    localparam int INIT_LIMIT     = 200;
    // Sweep plus every operation at its longest, with half again as margin
    localparam int INIT_CYCLES    = 400;
    localparam int OP_COUNT       = 300;
    localparam int CYCLES_PER_OP  = 12;
    localparam int MAX_CYCLES     = (INIT_CYCLES + OP_COUNT * CYCLES_PER_OP) * 3 / 2;

    logic               clk;
    logic               srst;
    logic               init_done;
    logic               insert_rdy;
    logic               insert_req;
    state_id_pkg::key_t insert_key;
    state_id_pkg::id_t  insert_id;
    logic               delete_rdy;
    logic               delete_req;
    state_id_pkg::id_t  delete_id;
    logic               delete_ack;
    logic               delete_error;
    state_id_pkg::key_t delete_key;
    logic [7:0]         delete_state_mon;

    state_id_pkg::id_t  exp_insert_id;
    state_id_pkg::key_t exp_delete_key;
    logic               exp_delete_error;

    int          check_count;
    int          chk_errors;
    int          tb_errors;
    int          test_count;
    int          cycle_count = 0;
    logic [31:0] rng_state;

    // Reference model state
    logic               used_ids  [NUM_IDS];
    state_id_pkg::key_t id_to_key [NUM_IDS];
    logic               key_valid [NUM_KEYS];

    state_id_tracker dut0 (
        .clk              ( clk ),
        .srst             ( srst ),
        .init_done        ( init_done ),
        .insert_rdy       ( insert_rdy ),
        .insert_req       ( insert_req ),
        .insert_key       ( insert_key ),
        .insert_id        ( insert_id ),
        .delete_rdy       ( delete_rdy ),
        .delete_req       ( delete_req ),
        .delete_id        ( delete_id ),
        .delete_ack       ( delete_ack ),
        .delete_error     ( delete_error ),
        .delete_key       ( delete_key ),
        .delete_state_mon ( delete_state_mon )
    );

    state_id_tracker_checker checker0 (
        .clk              ( clk ),
        .srst             ( srst ),
        .insert_req       ( insert_req ),
        .insert_rdy       ( insert_rdy ),
        .insert_id        ( insert_id ),
        .delete_rdy       ( delete_rdy ),
        .delete_ack       ( delete_ack ),
        .delete_error     ( delete_error ),
        .delete_key       ( delete_key ),
        .delete_state_mon ( delete_state_mon ),
        .exp_insert_id    ( exp_insert_id ),
        .exp_delete_key   ( exp_delete_key ),
        .exp_delete_error ( exp_delete_error ),
        .check_count      ( check_count ),
        .error_count      ( chk_errors )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ----------------------------------------
    // Random numbers and reference model
    // ----------------------------------------
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic state_id_pkg::id_t ref_lowest_free();
        for (int i = 0; i < NUM_IDS; i++) begin
            if (!used_ids[i]) return state_id_pkg::id_t'(i);
        end
        return '0;
    endfunction

    // Error when the table holds no valid entry, and then the ID stays in use
    function automatic void ref_delete(input state_id_pkg::id_t id,
                                       output state_id_pkg::key_t key, output logic err);
        key = id_to_key[id];
        err = !key_valid[key];
        if (!err) begin
            key_valid[key] = 1'b0;
            used_ids[id]   = 1'b0;
        end
    endfunction

    function automatic int count_used();
        int n;
        n = 0;
        for (int i = 0; i < NUM_IDS; i++) n += int'(used_ids[i]);
        return n;
    endfunction

    function automatic state_id_pkg::key_t pick_absent_key();
        int k;
        k = int'(next_random() % NUM_KEYS);
        while (key_valid[k]) k = (k + 1) % NUM_KEYS;
        return state_id_pkg::key_t'(k);
    endfunction

    function automatic state_id_pkg::id_t pick_used_id();
        int i;
        i = int'(next_random() % NUM_IDS);
        while (!used_ids[i]) i = (i + 1) % NUM_IDS;
        return state_id_pkg::id_t'(i);
    endfunction

    // ----------------------------------------
    // Operations, each starts and ends 2 ns after a rising edge
    // ----------------------------------------
    task automatic do_insert(input state_id_pkg::key_t key);
        exp_insert_id = ref_lowest_free();
        insert_key    = key;
        insert_req    = 1'b1;
        @(negedge clk);
        while (!insert_rdy) @(negedge clk);
        @(posedge clk);
        #2;
        insert_req = 1'b0;
        used_ids[exp_insert_id] = 1'b1;
        id_to_key[exp_insert_id] = key;
        key_valid[key] = 1'b1;
    endtask

    task automatic do_delete(input state_id_pkg::id_t id);
        state_id_pkg::key_t key;
        logic               err;
        ref_delete(id, key, err);
        exp_delete_key   = key;
        exp_delete_error = err;
        delete_id        = id;
        delete_req       = 1'b1;
        @(negedge clk);
        while (!delete_rdy) @(negedge clk);
        @(posedge clk);
        #2;
        delete_req = 1'b0;
        @(negedge clk);
        while (!delete_ack) @(negedge clk);
        @(posedge clk);
        #2;
    endtask

    task automatic report_test(input string name, input int errs_before);
        int errs;
        errs = chk_errors + tb_errors - errs_before;
        test_count++;
        if (errs == 0) $display("Test %0d %s: ok", test_count, name);
        else           $display("Test %0d %s: %0d errors", test_count, name, errs);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin : main_seq
        int errs_before;
        int wait_cycles;
        srst             = 1'b1;
        insert_req       = 1'b0;
        insert_key       = '0;
        delete_req       = 1'b0;
        delete_id        = '0;
        exp_insert_id    = '0;
        exp_delete_key   = '0;
        exp_delete_error = 1'b0;
        tb_errors        = 0;
        test_count       = 0;
        rng_state        = 32'hda8871de;
        for (int i = 0; i < NUM_IDS; i++) begin
            used_ids[i]  = 1'b0;
            id_to_key[i] = '0;
        end
        for (int k = 0; k < NUM_KEYS; k++) key_valid[k] = 1'b0;

        repeat (10) @(posedge clk);
        #2;
        srst = 1'b0;

        // Init
        errs_before = 0;
        wait_cycles = 0;
        while (!(init_done && insert_rdy) && wait_cycles < INIT_LIMIT) begin
            @(posedge clk);
            #2;
            wait_cycles++;
        end
        if (!init_done) begin
            $display("init_done did not rise within %0d cycles of reset", INIT_LIMIT);
            tb_errors++;
        end
        if (!insert_rdy) begin
            $display("insert_rdy did not rise within %0d cycles of reset", INIT_LIMIT);
            tb_errors++;
        end
        report_test("init", errs_before);

        if (tb_errors == 0) begin
            // Fill every ID
            errs_before = chk_errors + tb_errors;
            for (int i = 0; i < NUM_IDS; i++) do_insert(pick_absent_key());
            if (insert_rdy) begin
                $display("ERROR at %0t: insert_rdy high with every ID in use", $time);
                tb_errors++;
            end
            report_test("fill", errs_before);

            errs_before = chk_errors + tb_errors;
            do_delete(3);
            do_delete(7);
            report_test("delete", errs_before);

            errs_before = chk_errors + tb_errors;
            do_insert(pick_absent_key());
            do_insert(pick_absent_key());
            report_test("reuse", errs_before);

            // Second delete finds no entry and must not free the ID again
            errs_before = chk_errors + tb_errors;
            do_delete(3);
            do_delete(3);
            do_insert(pick_absent_key());
            report_test("stale delete", errs_before);

            errs_before = chk_errors + tb_errors;
            for (int n = 0; n < NUM_RANDOM_OPS; n++) begin
                if (count_used() == 0) do_insert(pick_absent_key());
                else if (count_used() == NUM_IDS) do_delete(pick_used_id());
                else if (((next_random() >> 7) & 32'd1) != 0) do_insert(pick_absent_key());
                else do_delete(pick_used_id());
            end
            report_test("random mix", errs_before);
        end

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : state_id_tracker_tb

// File: state_id_tracker.f
+incdir+rtl
rtl/state_id_pkg.sv
rtl/ram_sdp.sv
rtl/id_alloc_bv.sv
rtl/key_id_table.sv
rtl/state_id_manager.sv
rtl/state_id_tracker.sv
tb/state_id_tracker_checker.sv
tb/state_id_tracker_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the tracker testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module state_id_tracker_tb -f state_id_tracker.f \
    && ./obj_dir/Vstate_id_tracker_tb > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "Build or run failed"; exit 1; }

cat "$LOG"
grep -q "TEST FAIL" "$LOG" && { echo "Simulation reported failure"; exit 1; }
grep -q "TEST PASS" "$LOG" || { echo "No result found in $LOG"; exit 1; }
exit 0
